/* sv32_pkg.sv */
package sv32_pkg;

    // --------------------
    // widths and vectors
    // --------------------
    localparam int unsigned VADDR_W = 32;
    localparam int unsigned PADDR_W = 34;
    localparam int unsigned PPN_W   = 22;

    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    // vpn is vaddr[31:12], split into vpn1 = [19:10] and vpn0 = [9:0]
    typedef logic [19:0]        vpn_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [3:0]         cause_t;

    localparam int unsigned TLB_ENTRIES   = 4;
    localparam int unsigned PAGE_OFFSET_W = 12;
    // one pte is 4 bytes
    localparam int unsigned PTE_SIZE_LOG2 = 2;

    // mcause codes for data side faults
    localparam cause_t CAUSE_LD_ACCESS = 4'd5;
    localparam cause_t CAUSE_ST_ACCESS = 4'd7;
    localparam cause_t CAUSE_LD_PAGE   = 4'd13;
    localparam cause_t CAUSE_ST_PAGE   = 4'd15;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // --------------------
    // structs
    // --------------------
    // sv32 pte, msb first
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef struct packed {
        logic   valid;
        cause_t cause;
        vaddr_t tval;
    } exception_t;

    // refill from the walker into the tlb
    typedef struct packed {
        logic valid;
        vpn_t vpn;
        pte_t pte;
        logic is_4m;
    } tlb_update_t;

    // axi4-lite read address and read data handshakes, master side
    typedef struct packed {
        logic   ar_valid;
        paddr_t ar_addr;
        logic   r_ready;
    } axil_ar_req_t;

    typedef struct packed {
        logic        ar_ready;
        logic        r_valid;
        logic [31:0] r_data;
        logic [1:0]  r_resp;
    } axil_r_rsp_t;

    // walker FSM
    typedef enum logic [2:0] {
        IDLE,
        WAIT_AR,
        WAIT_R,
        UPDATE,
        ERROR
    } ptw_state_e;

endpackage

/* sv32_tlb.sv */
`timescale 1ns/1ps

module sv32_tlb import sv32_pkg::*; #(
    parameter int unsigned NR_ENTRIES = TLB_ENTRIES
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    // refill port from the walker
    input  tlb_update_t update_i,
    // lookup port
    input  logic        lu_access_i,
    input  vpn_t        lu_vpn_i,
    output logic        lu_hit_o,
    output pte_t        lu_pte_o,
    output logic        lu_is_4m_o
);

    localparam int unsigned PTR_W = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1;

    // tag keeps the full vpn, megapages ignore the low half on compare
    typedef struct packed {
        vpn_t tag;
        pte_t pte;
        logic is_4m;
    } tlb_entry_t;

    logic [NR_ENTRIES-1:0] valid_q;
    tlb_entry_t            entry_q [NR_ENTRIES];
    logic [NR_ENTRIES-1:0] match;
    logic [PTR_W-1:0]      rr_ptr_q;

    // --------------------
    // lookup
    // --------------------
    always_comb begin
        for (int i = 0; i < NR_ENTRIES; i++) begin
            // vpn1 always has to match
            match[i] = valid_q[i] && (entry_q[i].tag[19:10] == lu_vpn_i[19:10]);
            // vpn0 only for 4k pages
            if (!entry_q[i].is_4m && (entry_q[i].tag[9:0] != lu_vpn_i[9:0])) begin
                match[i] = 1'b0;
            end
        end
    end

    always_comb begin
        lu_hit_o   = 1'b0;
        lu_pte_o   = '0;
        lu_is_4m_o = 1'b0;
        // lowest index wins, a walk only runs on a miss so duplicates should not exist
        for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
            if (lu_access_i && match[i]) begin
                lu_hit_o   = 1'b1;
                lu_pte_o   = entry_q[i].pte;
                lu_is_4m_o = entry_q[i].is_4m;
            end
        end
    end

    // --------------------
    // refill and flush
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else begin
            // flush beats a refill in the same cycle
            if (flush_i) begin
                valid_q <= '0;
            end else if (update_i.valid) begin
                valid_q[rr_ptr_q] <= 1'b1;
            end
            // round robin victim, moves on every refill
            if (update_i.valid) begin
                if (rr_ptr_q == PTR_W'(NR_ENTRIES - 1)) begin
                    rr_ptr_q <= '0;
                end else begin
                    rr_ptr_q <= rr_ptr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            entry_q[rr_ptr_q].tag   <= update_i.vpn;
            entry_q[rr_ptr_q].pte   <= update_i.pte;
            entry_q[rr_ptr_q].is_4m <= update_i.is_4m;
        end
    end

endmodule

/* sv32_ptw.sv */
`timescale 1ns/1ps

module sv32_ptw import sv32_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         en_translation_i,
    input  ppn_t         satp_ppn_i,
    // dtlb lookup being watched
    input  logic         lu_access_i,
    input  logic         lu_hit_i,
    input  vpn_t         lu_vpn_i,
    // axi4-lite read master
    output axil_ar_req_t axi_req_o,
    input  axil_r_rsp_t  axi_rsp_i,
    // refill and status
    output tlb_update_t  update_o,
    output logic         walk_active_o,
    output logic         walk_error_o,
    output logic         walk_access_fault_o
);

    ptw_state_e state_q, state_d;
    // high while the level 1 pte is being fetched
    logic       level1_q, level1_d;
    // error kind for the ERROR state, access fault or page fault
    logic       acc_fault_q, acc_fault_d;
    vpn_t       vpn_q, vpn_d;
    ppn_t       ppn_q, ppn_d;
    pte_t       pte_q, pte_d;
    pte_t       rsp_pte;
    ppn_t       lvl_base;
    logic [9:0] lvl_idx;

    assign rsp_pte = pte_t'(axi_rsp_i.r_data);

    // --------------------
    // pte address
    // --------------------
    // level 1 table from satp, level 0 table from the pointer pte
    assign lvl_base = level1_q ? satp_ppn_i : ppn_q;
    assign lvl_idx  = level1_q ? vpn_q[19:10] : vpn_q[9:0];

    always_comb begin
        axi_req_o.ar_valid = (state_q == WAIT_AR);
        // built from registers only, stays put until ar_ready
        axi_req_o.ar_addr  = (paddr_t'(lvl_base) << PAGE_OFFSET_W)
                           | (paddr_t'(lvl_idx) << PTE_SIZE_LOG2);
        axi_req_o.r_ready  = (state_q == WAIT_R);
    end

    // --------------------
    // walker FSM
    // --------------------
    always_comb begin
        state_d     = state_q;
        level1_d    = level1_q;
        acc_fault_d = acc_fault_q;
        vpn_d       = vpn_q;
        ppn_d       = ppn_q;
        pte_d       = pte_q;

        unique case (state_q)
            IDLE: begin
                // start on a dtlb miss, capture the missing vpn
                if (en_translation_i && lu_access_i && !lu_hit_i) begin
                    vpn_d       = lu_vpn_i;
                    level1_d    = 1'b1;
                    acc_fault_d = 1'b0;
                    state_d     = WAIT_AR;
                end
            end
            WAIT_AR: begin
                if (axi_rsp_i.ar_ready) begin
                    state_d = WAIT_R;
                end
            end
            WAIT_R: begin
                if (axi_rsp_i.r_valid) begin
                    if (axi_rsp_i.r_resp != AXI_RESP_OKAY) begin
                        // bus error on the pte read
                        acc_fault_d = 1'b1;
                        state_d     = ERROR;
                    end else if (!rsp_pte.v || (rsp_pte.w && !rsp_pte.r)) begin
                        // invalid pte or reserved w-without-r encoding
                        state_d = ERROR;
                    end else if (rsp_pte.r || rsp_pte.x) begin
                        // leaf
                        if (level1_q && (rsp_pte.ppn0 != '0)) begin
                            // misaligned megapage
                            state_d = ERROR;
                        end else if (!rsp_pte.a) begin
                            // a bits are never set in memory here
                            state_d = ERROR;
                        end else begin
                            // d vs store is left to the hit path
                            pte_d   = rsp_pte;
                            state_d = UPDATE;
                        end
                    end else if (!level1_q) begin
                        // pointer at the last level
                        state_d = ERROR;
                    end else begin
                        // next level table
                        ppn_d    = {rsp_pte.ppn1, rsp_pte.ppn0};
                        level1_d = 1'b0;
                        state_d  = WAIT_AR;
                    end
                end
            end
            // single cycle states, back to idle
            UPDATE:  state_d = IDLE;
            ERROR:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // --------------------
    // outputs
    // --------------------
    always_comb begin
        update_o.valid = (state_q == UPDATE);
        update_o.vpn   = vpn_q;
        update_o.pte   = pte_q;
        // leaf found while still on level 1
        update_o.is_4m = level1_q;
    end

    assign walk_active_o       = (state_q != IDLE);
    assign walk_error_o        = (state_q == ERROR) && !acc_fault_q;
    assign walk_access_fault_o = (state_q == ERROR) && acc_fault_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            level1_q    <= 1'b1;
            acc_fault_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            level1_q    <= level1_d;
            acc_fault_q <= acc_fault_d;
        end
    end

    always_ff @(posedge clk_i) begin
        vpn_q <= vpn_d;
        ppn_q <= ppn_d;
        pte_q <= pte_d;
    end

endmodule

/* sv32_lsu_xlate.sv */
`timescale 1ns/1ps

module sv32_lsu_xlate import sv32_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    // lsu request
    input  logic       lsu_req_i,
    input  vaddr_t     lsu_vaddr_i,
    input  logic       lsu_is_store_i,
    // csr state
    input  logic       en_translation_i,
    input  logic       user_mode_i,
    input  logic       sum_i,
    // dtlb lookup
    output logic       lu_access_o,
    output vpn_t       lu_vpn_o,
    input  logic       lu_hit_i,
    input  pte_t       lu_pte_i,
    input  logic       lu_is_4m_i,
    // walker status
    input  logic       walk_active_i,
    input  logic       walk_error_i,
    input  logic       walk_access_fault_i,
    // response, one cycle after the request on hit or bare
    output logic       lsu_valid_o,
    output paddr_t     lsu_paddr_o,
    output exception_t lsu_exception_o
);

    logic   req_q;
    logic   store_q;
    logic   hit_q;
    vaddr_t vaddr_q;
    pte_t   pte_q;
    logic   is_4m_q;
    logic   priv_err;
    logic   walk_fault;
    paddr_t paddr_4k;
    paddr_t paddr_4m;

    function automatic exception_t make_exc(cause_t cause, vaddr_t tval);
        exception_t exc;
        exc.valid = 1'b1;
        exc.cause = cause;
        exc.tval  = tval;
        return exc;
    endfunction

    // lookup only matters when translating
    assign lu_access_o = lsu_req_i && en_translation_i;
    assign lu_vpn_o    = lsu_vaddr_i[VADDR_W-1:PAGE_OFFSET_W];

    // --------------------
    // address formation
    // --------------------
    assign paddr_4k = {pte_q.ppn1, pte_q.ppn0, vaddr_q[PAGE_OFFSET_W-1:0]};
    assign paddr_4m = {pte_q.ppn1, vaddr_q[21:0]};

    // user may only touch u pages, supervisor needs sum for them
    assign priv_err   = user_mode_i ? !pte_q.u : (pte_q.u && !sum_i);
    assign walk_fault = walk_active_i && (walk_error_i || walk_access_fault_i);

    always_comb begin
        // bare mode, zero-extended pass through
        lsu_valid_o     = req_q;
        lsu_paddr_o     = paddr_t'(vaddr_q);
        lsu_exception_o = '0;

        if (en_translation_i) begin
            // a miss waits for the refill or a walk fault
            lsu_valid_o = req_q && (hit_q || walk_fault);
            lsu_paddr_o = is_4m_q ? paddr_4m : paddr_4k;

            if (req_q && hit_q) begin
                if (store_q) begin
                    // store needs w, d and privilege
                    if (!pte_q.w || !pte_q.d || priv_err) begin
                        lsu_exception_o = make_exc(CAUSE_ST_PAGE, vaddr_q);
                    end
                end else if (!pte_q.r || priv_err) begin
                    lsu_exception_o = make_exc(CAUSE_LD_PAGE, vaddr_q);
                end
            end else if (req_q && walk_fault) begin
                // walker faults follow the access type
                if (walk_error_i) begin
                    lsu_exception_o = make_exc(store_q ? CAUSE_ST_PAGE : CAUSE_LD_PAGE,
                                               vaddr_q);
                end else begin
                    lsu_exception_o = make_exc(store_q ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS,
                                               vaddr_q);
                end
            end
        end
    end

    // --------------------
    // request register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q   <= 1'b0;
            store_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            req_q   <= lsu_req_i;
            store_q <= lsu_is_store_i;
            hit_q   <= lu_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= lsu_vaddr_i;
        pte_q   <= lu_pte_i;
        is_4m_q <= lu_is_4m_i;
    end

endmodule

/* sv32_mmu.sv */
`timescale 1ns/1ps

module sv32_mmu import sv32_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    // csr state
    input  logic         en_translation_i,
    input  logic         user_mode_i,
    input  logic         sum_i,
    input  ppn_t         satp_ppn_i,
    input  logic         flush_tlb_i,
    // lsu side
    input  logic         lsu_req_i,
    input  vaddr_t       lsu_vaddr_i,
    input  logic         lsu_is_store_i,
    output logic         lsu_valid_o,
    output paddr_t       lsu_paddr_o,
    output exception_t   lsu_exception_o,
    // pte reads
    output axil_ar_req_t axi_req_o,
    input  axil_r_rsp_t  axi_rsp_i
);

    // dtlb lookup
    logic        lu_access;
    vpn_t        lu_vpn;
    logic        lu_hit;
    pte_t        lu_pte;
    logic        lu_is_4m;
    // walker to tlb and translation stage
    tlb_update_t ptw_update;
    logic        walk_active;
    logic        walk_error;
    logic        walk_access_fault;

    sv32_tlb #(
        .NR_ENTRIES ( TLB_ENTRIES )
    ) i_dtlb (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .flush_i     ( flush_tlb_i ),
        .update_i    ( ptw_update  ),
        .lu_access_i ( lu_access   ),
        .lu_vpn_i    ( lu_vpn      ),
        .lu_hit_o    ( lu_hit      ),
        .lu_pte_o    ( lu_pte      ),
        .lu_is_4m_o  ( lu_is_4m    )
    );

    sv32_ptw i_ptw (
        .clk_i               ( clk_i             ),
        .rst_ni              ( rst_ni            ),
        .en_translation_i    ( en_translation_i  ),
        .satp_ppn_i          ( satp_ppn_i        ),
        .lu_access_i         ( lu_access         ),
        .lu_hit_i            ( lu_hit            ),
        .lu_vpn_i            ( lu_vpn            ),
        .axi_req_o           ( axi_req_o         ),
        .axi_rsp_i           ( axi_rsp_i         ),
        .update_o            ( ptw_update        ),
        .walk_active_o       ( walk_active       ),
        .walk_error_o        ( walk_error        ),
        .walk_access_fault_o ( walk_access_fault )
    );

    sv32_lsu_xlate i_xlate (
        .clk_i               ( clk_i             ),
        .rst_ni              ( rst_ni            ),
        .lsu_req_i           ( lsu_req_i         ),
        .lsu_vaddr_i         ( lsu_vaddr_i       ),
        .lsu_is_store_i      ( lsu_is_store_i    ),
        .en_translation_i    ( en_translation_i  ),
        .user_mode_i         ( user_mode_i       ),
        .sum_i               ( sum_i             ),
        .lu_access_o         ( lu_access         ),
        .lu_vpn_o            ( lu_vpn            ),
        .lu_hit_i            ( lu_hit            ),
        .lu_pte_i            ( lu_pte            ),
        .lu_is_4m_i          ( lu_is_4m          ),
        .walk_active_i       ( walk_active       ),
        .walk_error_i        ( walk_error        ),
        .walk_access_fault_i ( walk_access_fault ),
        .lsu_valid_o         ( lsu_valid_o       ),
        .lsu_paddr_o         ( lsu_paddr_o       ),
        .lsu_exception_o     ( lsu_exception_o   )
    );

endmodule

/* sv32_mmu_assert.sv */
`timescale 1ns/1ps

module sv32_mmu_assert import sv32_pkg::*; (
    input logic         clk_i,
    input logic         rst_ni,
    input logic         lsu_valid_i,
    input exception_t   lsu_exception_i,
    input axil_ar_req_t axi_req_i,
    input axil_r_rsp_t  axi_rsp_i
);

    // --------------------
    // axi4-lite read side
    // --------------------
    // address phase holds until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        axi_req_i.ar_valid && !axi_rsp_i.ar_ready |=> axi_req_i.ar_valid
            && $stable(axi_req_i.ar_addr))
        else $error("ar_valid or ar_addr changed before ar_ready");

    // --------------------
    // lsu side
    // --------------------
    exc_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_exception_i.valid |-> lsu_valid_i)
        else $error("exception valid without lsu_valid_o");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !lsu_valid_i && !axi_req_i.ar_valid)
        else $error("lsu_valid_o or ar_valid high right after reset");

endmodule

bind sv32_mmu sv32_mmu_assert i_mmu_assert (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .lsu_valid_i     ( lsu_valid_o     ),
    .lsu_exception_i ( lsu_exception_o ),
    .axi_req_i       ( axi_req_o       ),
    .axi_rsp_i       ( axi_rsp_i       )
);

/* tb_sv32_mmu.sv */
`timescale 1ns/1ps

module tb_sv32_mmu import sv32_pkg::*; ();

    // --------------------
    // timing and bounds
    // --------------------
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 3;
    // worst walk is two levels of ar plus r, each up to 4 cycles
    localparam int WALK_CYCLES  = 2 * (4 + 4);
    localparam int RESP_BOUND   = WALK_CYCLES + 8;
    localparam int NUM_ACCESSES = 21;
    localparam int WATCHDOG_NS  = (NUM_ACCESSES * (RESP_BOUND + 2) + 50) * CLK_PERIOD;

    // page table layout, root at 0x1000 and one level 0 table at 0x2000
    localparam ppn_t ROOT_PPN = 22'h00001;
    localparam ppn_t L0_PPN   = 22'h00002;
    localparam ppn_t PPN_A    = 22'h12345;
    localparam ppn_t PPN_B    = 22'h0beef;
    localparam ppn_t PPN_C    = 22'h2a5a5;
    localparam ppn_t PPN_U    = 22'h31337;

    // pte flag byte {d, a, g, u, x, w, r, v}
    localparam logic [7:0] F_V  = 8'h01;
    localparam logic [7:0] F_R  = 8'h02;
    localparam logic [7:0] F_W  = 8'h04;
    localparam logic [7:0] F_U  = 8'h10;
    localparam logic [7:0] F_A  = 8'h40;
    localparam logic [7:0] F_D  = 8'h80;
    localparam logic [7:0] RWAD = F_V | F_R | F_W | F_A | F_D;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic         en_translation_i;
    logic         user_mode_i;
    logic         sum_i;
    ppn_t         satp_ppn_i;
    logic         flush_tlb_i;
    logic         lsu_req_i;
    vaddr_t       lsu_vaddr_i;
    logic         lsu_is_store_i;
    logic         lsu_valid_o;
    paddr_t       lsu_paddr_o;
    exception_t   lsu_exception_o;
    axil_ar_req_t axi_req_o;
    axil_r_rsp_t  axi_rsp_i;

    int           errors = 0;
    int           checks = 0;
    int           ar_count = 0;
    logic [31:0]  lfsr_q = 32'h6d773a62;
    logic [31:0]  pt_mem [paddr_t];
    paddr_t       slverr_addr;
    paddr_t       resp_paddr;
    exception_t   resp_exc;
    int           resp_lat;

    sv32_mmu sv32_mmu_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // helpers
    // --------------------
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin
            lfsr_q = lfsr_step(lfsr_q);
            d = (d << 1) | int'(lfsr_q[0]);
        end
    endtask

    // sv32 pte: ppn, two rsw bits, flag byte
    function automatic logic [31:0] leaf(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic paddr_t pte_addr(input ppn_t table_ppn, input logic [9:0] idx);
        return {table_ppn, idx, 2'b00};
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic load_tables();
        // root, indexed by vaddr[31:22]
        pt_mem[pte_addr(ROOT_PPN, 10'd1)] = leaf(L0_PPN, F_V);
        pt_mem[pte_addr(ROOT_PPN, 10'd2)] = leaf({12'h3ab, 10'h000}, RWAD);
        pt_mem[pte_addr(ROOT_PPN, 10'd3)] = leaf({12'h3ac, 10'h005}, RWAD);
        // level 0, indexed by vaddr[21:12], index 4 left empty
        pt_mem[pte_addr(L0_PPN, 10'd0)] = leaf(PPN_A, RWAD);
        pt_mem[pte_addr(L0_PPN, 10'd1)] = leaf(PPN_B, F_V | F_R | F_A | F_D);
        pt_mem[pte_addr(L0_PPN, 10'd2)] = leaf(PPN_C, F_V | F_R | F_W | F_A);
        pt_mem[pte_addr(L0_PPN, 10'd3)] = leaf(PPN_U, RWAD | F_U);
        pt_mem[pte_addr(L0_PPN, 10'd5)] = leaf(PPN_A, RWAD);
        slverr_addr = pte_addr(L0_PPN, 10'd5);
    endtask

    // --------------------
    // axi4-lite pte memory
    // --------------------
    initial begin : axi_mem
        int     d;
        paddr_t addr;
        axi_rsp_i = '0;
        next_cycle();
        forever begin
            if (axi_req_o.ar_valid) begin
                draw_delay(d);
                repeat (d) next_cycle();
                addr = axi_req_o.ar_addr;
                axi_rsp_i.ar_ready = 1'b1;
                next_cycle();
                axi_rsp_i.ar_ready = 1'b0;
                ar_count++;
                draw_delay(d);
                repeat (d) next_cycle();
                // unwritten words read as an invalid pte
                axi_rsp_i.r_valid = 1'b1;
                axi_rsp_i.r_data  = pt_mem.exists(addr) ? pt_mem[addr] : '0;
                axi_rsp_i.r_resp  = (addr == slverr_addr) ? 2'b10 : AXI_RESP_OKAY;
                next_cycle();
                axi_rsp_i = '0;
            end else begin
                next_cycle();
            end
        end
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s: paddr expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_exc(input string name, input exception_t exp, input exception_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s: exception expected valid=%0b cause=%0d tval=%h, actual %s",
                     name, exp.valid, exp.cause, exp.tval,
                     $sformatf("valid=%0b cause=%0d tval=%h", act.valid, act.cause, act.tval));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Error: %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // one request, held until lsu_valid_o shows up
    task automatic access(input string name, input vaddr_t va, input logic store);
        lsu_req_i      = 1'b1;
        lsu_vaddr_i    = va;
        lsu_is_store_i = store;
        resp_lat       = 0;
        do begin
            @(posedge clk_i);
            @(negedge clk_i);
            resp_lat++;
        end while (!lsu_valid_o && resp_lat < RESP_BOUND);
        if (!lsu_valid_o) begin
            errors++;
            $display("Error: %s: the MMU gave no response within %0d cycles", name, RESP_BOUND);
        end
        resp_paddr = lsu_paddr_o;
        resp_exc   = lsu_exception_o;
        // drop the request, then one quiet cycle
        next_cycle();
        lsu_req_i = 1'b0;
        next_cycle();
    endtask

    task automatic expect_ok(input string name, input vaddr_t va, input logic store,
                             input paddr_t exp_pa);
        access(name, va, store);
        check_paddr(name, exp_pa, resp_paddr);
        check_exc(name, '0, resp_exc);
    endtask

    task automatic expect_fault(input string name, input vaddr_t va, input logic store,
                                input cause_t cause);
        exception_t exp;
        exp.valid = 1'b1;
        exp.cause = cause;
        exp.tval  = va;
        access(name, va, store);
        check_exc(name, exp, resp_exc);
    endtask

    // --------------------
    // directed tests
    // --------------------
    // back to back, the answer for request i shows in cycle i+1
    task automatic test_bare();
        vaddr_t va [4];
        va = '{32'h0000_0000, 32'h1234_5678, 32'hffff_fffc, 32'h8000_0abc};
        en_translation_i = 1'b0;
        for (int i = 0; i <= 4; i++) begin
            lsu_req_i = (i < 4);
            if (i < 4) begin
                lsu_vaddr_i    = va[i];
                lsu_is_store_i = i[0];
            end
            @(negedge clk_i);
            if (i > 0) begin
                check_count("bare valid", 1, int'(lsu_valid_o));
                check_paddr("bare paddr", paddr_t'(va[i-1]), lsu_paddr_o);
                check_exc("bare exception", '0, lsu_exception_o);
            end
            next_cycle();
        end
        @(negedge clk_i);
        check_count("bare idle", 0, int'(lsu_valid_o));
        next_cycle();
    endtask

    task automatic test_walk_4k();
        int reads;
        en_translation_i = 1'b1;
        reads = ar_count;
        expect_ok("walk 4k load", 32'h0040_0abc, 1'b0, {PPN_A, 12'habc});
        // root pointer, then the leaf
        check_count("walk 4k reads", reads + 2, ar_count);
        reads = ar_count;
        expect_ok("hit 4k store", 32'h0040_0ff0, 1'b1, {PPN_A, 12'hff0});
        check_count("hit 4k latency", 1, resp_lat);
        check_count("hit 4k reads", reads, ar_count);
    endtask

    task automatic test_megapage();
        int reads;
        reads = ar_count;
        expect_ok("megapage load", 32'h0089_abcd, 1'b0, {12'h3ab, 22'h09abcd});
        check_count("megapage reads", reads + 1, ar_count);
        expect_fault("misaligned megapage", 32'h00c0_1234, 1'b0, CAUSE_LD_PAGE);
    endtask

    task automatic test_permissions();
        expect_fault("store to read-only page", 32'h0040_1004, 1'b1, CAUSE_ST_PAGE);
        expect_ok("load from clean page", 32'h0040_2008, 1'b0, {PPN_C, 12'h008});
        expect_fault("store to clean page", 32'h0040_2008, 1'b1, CAUSE_ST_PAGE);
        user_mode_i = 1'b1;
        expect_fault("user on supervisor page", 32'h0040_0010, 1'b0, CAUSE_LD_PAGE);
        user_mode_i = 1'b0;
        expect_fault("supervisor on user page", 32'h0040_3010, 1'b0, CAUSE_LD_PAGE);
        sum_i = 1'b1;
        expect_ok("supervisor on user page with sum", 32'h0040_3010, 1'b0, {PPN_U, 12'h010});
        sum_i = 1'b0;
    endtask

    task automatic test_walk_faults();
        expect_fault("invalid pte load", 32'h0040_4000, 1'b0, CAUSE_LD_PAGE);
        expect_fault("invalid pte store", 32'h0040_4004, 1'b1, CAUSE_ST_PAGE);
        expect_fault("slverr load", 32'h0040_5000, 1'b0, CAUSE_LD_ACCESS);
        expect_fault("slverr store", 32'h0040_5008, 1'b1, CAUSE_ST_ACCESS);
    endtask

    task automatic test_flush();
        int reads;
        expect_ok("flush warm up", 32'h0040_0123, 1'b0, {PPN_A, 12'h123});
        reads = ar_count;
        expect_ok("flush before", 32'h0040_0123, 1'b0, {PPN_A, 12'h123});
        check_count("flush before reads", reads, ar_count);
        flush_tlb_i = 1'b1;
        next_cycle();
        flush_tlb_i = 1'b0;
        reads = ar_count;
        expect_ok("flush after", 32'h0040_0123, 1'b0, {PPN_A, 12'h123});
        check_count("flush after reads", reads + 2, ar_count);
    endtask

    initial begin : main
        rst_ni           = 1'b0;
        en_translation_i = 1'b0;
        user_mode_i      = 1'b0;
        sum_i            = 1'b0;
        satp_ppn_i       = ROOT_PPN;
        flush_tlb_i      = 1'b0;
        lsu_req_i        = 1'b0;
        lsu_vaddr_i      = '0;
        lsu_is_store_i   = 1'b0;
        load_tables();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_ni = 1'b1;
        next_cycle();
        test_bare();
        test_walk_4k();
        test_megapage();
        test_permissions();
        test_walk_faults();
        test_flush();
        $display("tb_sv32_mmu: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Error: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("tb_sv32_mmu: %0d errors in %0d checks", errors, checks);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* sources.f */
sv32_pkg.sv
sv32_tlb.sv
sv32_ptw.sv
sv32_lsu_xlate.sv
sv32_mmu.sv
sv32_mmu_assert.sv
tb_sv32_mmu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sv32 mmu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_sv32_mmu -f sources.f

out=$(./obj_dir/Vtb_sv32_mmu) || true
echo "$out"
if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
